// File: list.f
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/exe_hilo.sv
rtl/exe_mem_request.sv
rtl/exe_stage.sv
verification/exe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module exe_tb -f list.f -Mdir obj_dir -o exe_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/exe_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$log"; then
    exit 0
fi
exit 1

// File: verification/exe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_tb import exe_pkg::*; ();

    typedef struct packed {
        logic       wr;
        sram_size_t size;
        byte_en_t   strb;
        word_t      addr;
        word_t      data;
    } sram_req_t;

    localparam int STREAM_TIMEOUT = 20000;

    logic        clk;
    logic        reset;
    logic        in_valid;
    dec_to_exe_t in_bus;
    logic        allowin;
    logic        out_valid;
    exe_to_mem_t out_bus;
    logic        mem_allowin;
    logic        sram_en;
    logic        sram_wr;
    sram_size_t  sram_size;
    byte_en_t    sram_wstrb;
    word_t       sram_addr;
    word_t       sram_wdata;
    logic        sram_addr_ok;

    integer      seed = 9;
    int          error_count;
    int          check_count;
    int          test_count;
    logic        timed_out;
    word_t       model_hi;
    word_t       model_lo;
    dec_to_exe_t stim_q[$];
    exe_to_mem_t exp_q[$];
    sram_req_t   req_q[$];

    exe_stage u_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .allowin      (allowin),
        .out_valid    (out_valid),
        .out_bus      (out_bus),
        .mem_allowin  (mem_allowin),
        .sram_en      (sram_en),
        .sram_wr      (sram_wr),
        .sram_size    (sram_size),
        .sram_wstrb   (sram_wstrb),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_addr_ok (sram_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_out(input exe_to_mem_t got, input exe_to_mem_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %0t: out_bus pc %h result %h exc %0d bad %h dest %0d we %b",
                     $time, got.pc, got.result, got.exc_code, got.bad_vaddr,
                     got.dest, got.gr_we);
            $display("    expected pc %h result %h exc %0d bad %h dest %0d we %b",
                     exp.pc, exp.result, exp.exc_code, exp.bad_vaddr, exp.dest, exp.gr_we);
        end
    endtask

    task automatic check_sram(input sram_req_t got, input sram_req_t exp);
        check_count++;
        if (got.wr !== exp.wr || got.size !== exp.size || got.strb !== exp.strb
            || got.addr !== exp.addr || (exp.wr && got.data !== exp.data)) begin
            error_count++;
            $display("FAILED %0t: sram wr %b size %0d strb %b addr %h data %h",
                     $time, got.wr, got.size, got.strb, got.addr, got.data);
            $display("    expected wr %b size %0d strb %b addr %h data %h",
                     exp.wr, exp.size, exp.strb, exp.addr, exp.data);
        end
    endtask

    // reference model, also advances the model hi/lo in program order
    task automatic model_step(input dec_to_exe_t d);
        word_t       s1;
        word_t       s2;
        word_t       res;
        logic [32:0] wide;
        logic [63:0] prod;
        logic        ov;
        logic        misaligned;
        logic        store;
        exe_to_mem_t e;
        sram_req_t   r;
        case (d.src1_sel)
            SRC1_SA: s1 = word_t'(d.imm[10:6]);
            SRC1_PC: s1 = d.pc;
            default: s1 = d.rs_value;
        endcase
        case (d.src2_sel)
            SRC2_IMM_SIGN: s2 = word_t'($signed(d.imm));
            SRC2_IMM_ZERO: s2 = word_t'(d.imm);
            SRC2_CONST8:   s2 = 32'd8;
            default:       s2 = d.rt_value;
        endcase
        case (d.alu_op)
            ALU_ADD:  res = s1 + s2;
            ALU_SUB:  res = s1 - s2;
            ALU_SLT:  res = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (s1 < s2) ? 32'd1 : 32'd0;
            ALU_AND:  res = s1 & s2;
            ALU_NOR:  res = ~s1 & ~s2;
            ALU_OR:   res = s1 | s2;
            ALU_XOR:  res = s1 ^ s2;
            ALU_SLL:  res = s2 << s1[4:0];
            ALU_SRL:  res = s2 >> s1[4:0];
            ALU_SRA:  res = word_t'($signed(s2) >>> s1[4:0]);
            ALU_LUI:  res = {s2[15:0], 16'h0000};
            default:  res = '0;
        endcase
        // 33-bit signed sum, overflow when the top two bits differ
        case (d.ov_check)
            OV_ADD:  wide = {s1[31], s1} + {s2[31], s2};
            OV_SUB:  wide = {s1[31], s1} - {s2[31], s2};
            default: wide = '0;
        endcase
        ov = wide[32] ^ wide[31];
        store = d.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
        case (d.mem_op)
            MEM_LW, MEM_SW:          misaligned = res[1] | res[0];
            MEM_LH, MEM_LHU, MEM_SH: misaligned = res[0];
            default:                 misaligned = 1'b0;
        endcase
        e.pc     = d.pc;
        e.dest   = d.dest;
        e.gr_we  = d.gr_we;
        e.mem_op = d.mem_op;
        e.result = (d.hilo_op == HILO_MFHI) ? model_hi
                 : (d.hilo_op == HILO_MFLO) ? model_lo : res;
        e.exc_code  = ov ? EXC_OV : !misaligned ? EXC_NONE : store ? EXC_ADES : EXC_ADEL;
        e.bad_vaddr = misaligned ? res : '0;
        exp_q.push_back(e);
        if (d.mem_op != MEM_NONE && !misaligned) begin
            r.wr   = store;
            r.addr = res;
            r.data = d.rt_value;
            r.size = SIZE_WORD;
            if (d.mem_op inside {MEM_LB, MEM_LBU, MEM_SB}) begin
                r.size = SIZE_BYTE;
            end else if (d.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) begin
                r.size = SIZE_HALF;
            end
            if (d.mem_op == MEM_SB) begin
                r.data = {4{d.rt_value[7:0]}};
            end else if (d.mem_op == MEM_SH) begin
                r.data = {2{d.rt_value[15:0]}};
            end
            for (int i = 0; i < 4; i++) begin
                case (d.mem_op)
                    MEM_SB:  r.strb[i] = (2'(i) == res[1:0]);
                    MEM_SH:  r.strb[i] = (1'(i / 2) == res[1]);
                    MEM_SW:  r.strb[i] = 1'b1;
                    default: r.strb[i] = 1'b0;
                endcase
            end
            req_q.push_back(r);
        end
        case (d.hilo_op)
            HILO_MULT: prod = longint'($signed(d.rs_value)) * longint'($signed(d.rt_value));
            HILO_MULTU: prod = 64'(d.rs_value) * 64'(d.rt_value);
            default: prod = {model_hi, model_lo};
        endcase
        if (d.hilo_op == HILO_MULT || d.hilo_op == HILO_MULTU) begin
            model_hi = prod[63:32];
            model_lo = prod[31:0];
        end else if (d.hilo_op == HILO_MTHI) begin
            model_hi = d.rs_value;
        end else if (d.hilo_op == HILO_MTLO) begin
            model_lo = d.rs_value;
        end
    endtask

    function automatic dec_to_exe_t rand_base();
        dec_to_exe_t d;
        d.pc       = $random(seed) & 32'hffff_fffc;
        d.rs_value = $random(seed);
        d.rt_value = $random(seed);
        d.imm      = imm_t'($random(seed));
        d.dest     = reg_addr_t'($random(seed));
        d.gr_we    = 1'($random(seed));
        d.alu_op   = ALU_ADD;
        d.src1_sel = SRC1_RS;
        d.src2_sel = SRC2_RT;
        d.mem_op   = MEM_NONE;
        d.hilo_op  = HILO_NONE;
        d.ov_check = OV_NONE;
        return d;
    endfunction

    function automatic dec_to_exe_t rand_alu();
        dec_to_exe_t d;
        d = rand_base();
        d.alu_op   = alu_op_t'(4'({$random(seed)} % 12));
        d.src1_sel = src1_sel_t'(2'({$random(seed)} % 3));
        d.src2_sel = src2_sel_t'(2'({$random(seed)} % 4));
        return d;
    endfunction

    function automatic dec_to_exe_t arith_instr(input logic want_ov, input logic sub);
        dec_to_exe_t d;
        d = rand_base();
        d.alu_op   = sub ? ALU_SUB : ALU_ADD;
        d.ov_check = sub ? OV_SUB : OV_ADD;
        if (want_ov) begin
            d.rs_value = 32'h7000_0000 | ({$random(seed)} & 32'h0fff_ffff);
            d.rt_value = (sub ? 32'h8000_0000 : 32'h7000_0000)
                         | ({$random(seed)} & 32'h0fff_ffff);
        end else begin
            d.rs_value = word_t'($random(seed) >>> 4);
            d.rt_value = word_t'($random(seed) >>> 4);
        end
        return d;
    endfunction

    function automatic dec_to_exe_t hilo_instr(input hilo_op_t op);
        dec_to_exe_t d;
        d = rand_base();
        d.hilo_op = op;
        return d;
    endfunction

    function automatic dec_to_exe_t mem_instr(input logic aligned);
        dec_to_exe_t d;
        word_t       addr;
        d = rand_base();
        d.src2_sel = SRC2_IMM_SIGN;
        addr = $random(seed);
        if (aligned) begin
            d.mem_op = mem_op_t'(4'(1 + {$random(seed)} % 8));
            if (d.mem_op inside {MEM_LW, MEM_SW}) begin
                addr[1:0] = 2'b00;
            end else if (d.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) begin
                addr[0] = 1'b0;
            end
        end else begin
            case ({$random(seed)} % 4)
                0:       d.mem_op = MEM_LW;
                1:       d.mem_op = MEM_LH;
                2:       d.mem_op = MEM_SW;
                default: d.mem_op = MEM_SH;
            endcase
            if (d.mem_op inside {MEM_LW, MEM_SW}) begin
                addr[1:0] = 2'(1 + {$random(seed)} % 3);
            end else begin
                addr[0] = 1'b1;
            end
        end
        d.rs_value = addr - word_t'($signed(d.imm));
        return d;
    endfunction

    // feeds stim_q through the DUT with random back-pressure and sram latency
    task automatic run_stream(input string name);
        int          cycles;
        int          err0;
        int          n;
        logic        offering;
        dec_to_exe_t cur;
        sram_req_t   got_req;
        cycles   = 0;
        err0     = error_count;
        n        = stim_q.size();
        offering = 1'b0;
        cur      = in_bus;
        test_count++;
        while (!timed_out && (stim_q.size() > 0 || offering || exp_q.size() > 0)) begin
            @(negedge clk);
            mem_allowin  = ({$random(seed)} % 10) < 7;
            sram_addr_ok = sram_en && ({$random(seed)} % 2 == 1);
            if (!offering && stim_q.size() > 0 && ({$random(seed)} % 4) != 0) begin
                cur      = stim_q.pop_front();
                offering = 1'b1;
            end
            in_valid = offering;
            in_bus   = cur;
            #1;
            if (sram_en && req_q.size() == 0) begin
                error_count++;
                $display("%0t: sram_en raised with no request expected", $time);
            end else if (sram_en && sram_addr_ok) begin
                got_req = '{sram_wr, sram_size, sram_wstrb, sram_addr, sram_wdata};
                check_sram(got_req, req_q.pop_front());
            end
            if (out_valid && mem_allowin) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("%0t: output handed over with none expected", $time);
                end else begin
                    check_out(out_bus, exp_q.pop_front());
                end
            end
            if (in_valid && allowin) begin
                model_step(cur);
                offering = 1'b0;
            end
            cycles++;
            if (cycles >= STREAM_TIMEOUT) begin
                timed_out = 1'b1;
                $display("timeout: stream %s did not drain in %0d cycles", name, cycles);
            end
        end
        if (!timed_out && req_q.size() != 0) begin
            error_count++;
            $display("%0d sram requests never arrived in stream %s", req_q.size(), name);
        end
        req_q.delete();
        @(negedge clk);
        in_valid = 1'b0;
        $display("test %-14s %0d instructions, %0d errors", name, n, error_count - err0);
    endtask

    initial begin
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_bus       = '0;
        mem_allowin  = 1'b0;
        sram_addr_ok = 1'b0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 1;
        timed_out    = 1'b0;
        model_hi     = '0;
        model_lo     = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_count++;
        if (out_valid !== 1'b0 || sram_en !== 1'b0 || allowin !== 1'b1) begin
            error_count++;
            $display("FAILED %0t: after reset out_valid %b sram_en %b allowin %b",
                     $time, out_valid, sram_en, allowin);
        end
        $display("test %-14s %0d errors", "reset", error_count);

        repeat (200) stim_q.push_back(rand_alu());
        run_stream("alu_random");
        for (int i = 0; i < 80; i++) begin
            stim_q.push_back(arith_instr(1'(i % 2), 1'((i / 2) % 2)));
        end
        run_stream("overflow");
        for (int i = 0; i < 20; i++) begin
            stim_q.push_back(hilo_instr((i % 2 == 0) ? HILO_MULT : HILO_MULTU));
            stim_q.push_back(hilo_instr(HILO_MFHI));
            stim_q.push_back(hilo_instr(HILO_MFLO));
            stim_q.push_back(hilo_instr(HILO_MTHI));
            stim_q.push_back(hilo_instr(HILO_MFHI));
            stim_q.push_back(hilo_instr(HILO_MTLO));
            stim_q.push_back(hilo_instr(HILO_MFLO));
        end
        run_stream("hilo");
        repeat (80) stim_q.push_back(mem_instr(1'b1));
        run_stream("mem_aligned");
        repeat (40) stim_q.push_back(mem_instr(1'b0));
        run_stream("mem_misaligned");
        for (int i = 0; i < 300; i++) begin
            case ({$random(seed)} % 5)
                0: stim_q.push_back(rand_alu());
                1: stim_q.push_back(arith_instr(1'($random(seed)), 1'($random(seed))));
                2: stim_q.push_back(hilo_instr(hilo_op_t'(3'(1 + {$random(seed)} % 6))));
                3: stim_q.push_back(mem_instr(1'b1));
                default: stim_q.push_back(mem_instr(1'b0));
            endcase
        end
        run_stream("mixed");

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  dec_to_exe_t in_bus,
    output logic        allowin,
    output logic        out_valid,
    output exe_to_mem_t out_bus,
    input  logic        mem_allowin,
    output logic        sram_en,
    output logic        sram_wr,
    output sram_size_t  sram_size,
    output byte_en_t    sram_wstrb,
    output word_t       sram_addr,
    output word_t       sram_wdata,
    input  logic        sram_addr_ok
);

    logic        valid;
    dec_to_exe_t bus_r;
    logic        ready;
    logic        leaving;
    word_t       alu_result;
    logic        overflow;
    word_t       hi;
    word_t       lo;
    logic        addr_error;
    logic        req_done;
    word_t       result;
    exc_code_t   exc_code;

    assign ready     = req_done;
    assign out_valid = valid && ready;
    assign leaving   = out_valid && mem_allowin;
    assign allowin   = !valid || leaving;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            bus_r <= in_bus;
        end
    end

    exe_alu u_alu (
        .src1_sel   (bus_r.src1_sel),
        .src2_sel   (bus_r.src2_sel),
        .alu_op     (bus_r.alu_op),
        .ov_check   (bus_r.ov_check),
        .rs_value   (bus_r.rs_value),
        .rt_value   (bus_r.rt_value),
        .pc         (bus_r.pc),
        .imm        (bus_r.imm),
        .alu_result (alu_result),
        .overflow   (overflow)
    );

    // hi/lo change only when the instruction retires from this stage
    exe_hilo u_hilo (
        .clk      (clk),
        .reset    (reset),
        .commit   (leaving),
        .hilo_op  (bus_r.hilo_op),
        .rs_value (bus_r.rs_value),
        .rt_value (bus_r.rt_value),
        .hi       (hi),
        .lo       (lo)
    );

    exe_mem_request u_mem_request (
        .clk          (clk),
        .reset        (reset),
        .occupied     (valid),
        .leaving      (leaving),
        .mem_op       (bus_r.mem_op),
        .addr         (alu_result),
        .rt_value     (bus_r.rt_value),
        .sram_en      (sram_en),
        .sram_wr      (sram_wr),
        .sram_size    (sram_size),
        .sram_wstrb   (sram_wstrb),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_addr_ok (sram_addr_ok),
        .addr_error   (addr_error),
        .req_done     (req_done)
    );

    always_comb begin
        case (bus_r.hilo_op)
            HILO_MFHI: result = hi;
            HILO_MFLO: result = lo;
            default:   result = alu_result;
        endcase
    end

    // overflow first, then load error, then store error
    always_comb begin
        if (overflow) begin
            exc_code = EXC_OV;
        end else if (addr_error && !is_store(bus_r.mem_op)) begin
            exc_code = EXC_ADEL;
        end else if (addr_error) begin
            exc_code = EXC_ADES;
        end else begin
            exc_code = EXC_NONE;
        end
    end

    assign out_bus.pc        = bus_r.pc;
    assign out_bus.result    = result;
    assign out_bus.dest      = bus_r.dest;
    assign out_bus.gr_we     = bus_r.gr_we;
    assign out_bus.mem_op    = bus_r.mem_op;
    assign out_bus.exc_code  = exc_code;
    assign out_bus.bad_vaddr = addr_error ? alu_result : '0;

    // decode holds its offer while stalled
    assert property (@(posedge clk) disable iff (reset)
        in_valid && !allowin |=> $stable(in_bus));

    // a stalled result stays put, hi/lo and the request included
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !mem_allowin |=> out_valid && $stable(out_bus));

endmodule

`default_nettype wire

// File: rtl/exe_mem_request.sv
`timescale 1ns/1ps
`default_nettype none

module exe_mem_request import exe_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       occupied,
    input  logic       leaving,
    input  mem_op_t    mem_op,
    input  word_t      addr,
    input  word_t      rt_value,
    output logic       sram_en,
    output logic       sram_wr,
    output sram_size_t sram_size,
    output byte_en_t   sram_wstrb,
    output word_t      sram_addr,
    output word_t      sram_wdata,
    input  logic       sram_addr_ok,
    output logic       addr_error,
    output logic       req_done
);

    logic addr_accepted;
    logic mem_access;
    logic store;

    assign mem_access = (mem_op != MEM_NONE);
    assign store      = is_store(mem_op);

    always_comb begin
        case (mem_op)
            MEM_LW, MEM_SW:          addr_error = (addr[1:0] != 2'b00);
            MEM_LH, MEM_LHU, MEM_SH: addr_error = addr[0];
            default:                 addr_error = 1'b0;
        endcase
    end

    // size, byte lanes and replicated store data
    always_comb begin
        sram_size  = SIZE_WORD;
        sram_wstrb = 4'b0000;
        sram_wdata = rt_value;
        case (mem_op)
            MEM_LB, MEM_LBU: sram_size = SIZE_BYTE;
            MEM_LH, MEM_LHU: sram_size = SIZE_HALF;
            MEM_SB: begin
                sram_size  = SIZE_BYTE;
                sram_wstrb = 4'b0001 << addr[1:0];
                sram_wdata = {4{rt_value[7:0]}};
            end
            MEM_SH: begin
                sram_size  = SIZE_HALF;
                sram_wstrb = addr[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{rt_value[15:0]}};
            end
            MEM_SW: sram_wstrb = 4'b1111;
            default: ;
        endcase
    end

    // one request per instruction, held off once the address is taken
    assign sram_en   = occupied && mem_access && !addr_error && !addr_accepted;
    assign sram_wr   = store;
    assign sram_addr = addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_accepted <= 1'b0;
        end else if (leaving) begin
            addr_accepted <= 1'b0;
        end else if (sram_en && sram_addr_ok) begin
            addr_accepted <= 1'b1;
        end
    end

    assign req_done = !mem_access || addr_error || addr_accepted
                      || (sram_en && sram_addr_ok);

    // request must hold until the sram takes the address
    assert property (@(posedge clk) disable iff (reset)
        sram_en && !sram_addr_ok |=> sram_en && $stable(sram_addr));

endmodule

`default_nettype wire

// File: rtl/exe_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module exe_hilo import exe_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     commit,
    input  hilo_op_t hilo_op,
    input  word_t    rs_value,
    input  word_t    rt_value,
    output word_t    hi,
    output word_t    lo
);

    logic [63:0] prod_signed;
    logic [63:0] prod_unsigned;

    // operands widened to 64 bits, low half of the product kept
    assign prod_signed   = {{32{rs_value[31]}}, rs_value} * {{32{rt_value[31]}}, rt_value};
    assign prod_unsigned = {32'b0, rs_value} * {32'b0, rt_value};

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (hilo_op)
                HILO_MULT: begin
                    hi <= prod_signed[63:32];
                    lo <= prod_signed[31:0];
                end
                HILO_MULTU: begin
                    hi <= prod_unsigned[63:32];
                    lo <= prod_unsigned[31:0];
                end
                HILO_MTHI: hi <= rs_value;
                HILO_MTLO: lo <= rs_value;
                default: ;
            endcase
        end
    end

    // decode must never retire an instruction with an undefined hilo field
    assert property (@(posedge clk) disable iff (reset)
        commit |-> !$isunknown(hilo_op));

endmodule

`default_nettype wire

// File: rtl/exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
    input  src1_sel_t src1_sel,
    input  src2_sel_t src2_sel,
    input  alu_op_t   alu_op,
    input  ov_check_t ov_check,
    input  word_t     rs_value,
    input  word_t     rt_value,
    input  word_t     pc,
    input  imm_t      imm,
    output word_t     alu_result,
    output logic      overflow
);

    word_t      src1;
    word_t      src2;
    logic [4:0] shamt;

    always_comb begin
        case (src1_sel)
            SRC1_SA: src1 = {27'b0, imm[10:6]};
            SRC1_PC: src1 = pc;
            default: src1 = rs_value;
        endcase
    end

    always_comb begin
        case (src2_sel)
            SRC2_IMM_SIGN: src2 = {{16{imm[15]}}, imm};
            SRC2_IMM_ZERO: src2 = {16'b0, imm};
            SRC2_CONST8:   src2 = 32'd8;
            default:       src2 = rt_value;
        endcase
    end

    // shift amount from src1, shifted value from src2
    assign shamt = src1[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_result = {31'b0, src1 < src2};
            ALU_AND:  alu_result = src1 & src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_OR:   alu_result = src1 | src2;
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_SLL:  alu_result = src2 << shamt;
            ALU_SRL:  alu_result = src2 >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(src2) >>> shamt);
            ALU_LUI:  alu_result = {src2[15:0], 16'b0};
            default:  alu_result = '0;
        endcase
    end

    // signed overflow from operand and result signs
    always_comb begin
        case (ov_check)
            OV_ADD:  overflow = (src1[31] == src2[31]) && (alu_result[31] != src1[31]);
            OV_SUB:  overflow = (src1[31] != src2[31]) && (alu_result[31] != src1[31]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/exe_pkg.sv
`default_nettype none

package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  sram_size_t;

    // mips cause codes
    localparam exc_code_t EXC_NONE = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;

    localparam sram_size_t SIZE_BYTE = 2'd0;
    localparam sram_size_t SIZE_HALF = 2'd1;
    localparam sram_size_t SIZE_WORD = 2'd2;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR,  ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC1_RS, SRC1_SA, SRC1_PC
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RT, SRC2_IMM_SIGN, SRC2_IMM_ZERO, SRC2_CONST8
    } src2_sel_t;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU,
        MEM_SW, MEM_SH, MEM_SB
    } mem_op_t;

    typedef enum logic [2:0] {
        HILO_NONE, HILO_MULT, HILO_MULTU, HILO_MTHI, HILO_MTLO,
        HILO_MFHI, HILO_MFLO
    } hilo_op_t;

    typedef enum logic [1:0] {
        OV_NONE, OV_ADD, OV_SUB
    } ov_check_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs_value;
        word_t     rt_value;
        imm_t      imm;
        reg_addr_t dest;
        logic      gr_we;
        alu_op_t   alu_op;
        src1_sel_t src1_sel;
        src2_sel_t src2_sel;
        mem_op_t   mem_op;
        hilo_op_t  hilo_op;
        ov_check_t ov_check;
    } dec_to_exe_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      gr_we;
        mem_op_t   mem_op;
        exc_code_t exc_code;
        word_t     bad_vaddr;
    } exe_to_mem_t;

    function automatic logic is_store(mem_op_t op);
        is_store = (op == MEM_SW) || (op == MEM_SH) || (op == MEM_SB);
    endfunction

endpackage

`default_nettype wire
